// File: sim.f
common/udp_rx_pkg.sv
common/mac_word_if.sv
common/frame_verdict_if.sv
common/payload_word_if.sv
app_buffer/rx_word_fifo.sv
app_buffer/app_rx_buffer.sv
hw/udp_header_filter.sv
hw/payload_aligner.sv
hw/udp_rx_top.sv
tests/udp_rx_checker.sv
tests/tb_udp_rx.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, then decide from the log
verilator --binary --timing -Wno-fatal --top-module tb_udp_rx -f sim.f -o tb_udp_rx \
  > build.log 2>&1 \
  && ./obj_dir/tb_udp_rx > sim.log 2>&1 \
  || { echo "build or run error, see build.log and sim.log"; exit 1; }
cat sim.log
! grep -q "Something failed" sim.log && grep -q "Everything OK" sim.log

// File: tests/tb_udp_rx.sv
`timescale 1ns/1ns

module tb_udp_rx;
  import udp_rx_pkg::*;

  localparam int max_words = 512;
  localparam int clk_half = 20;
  // all frame words sent over the run
  localparam int total_frame_words = 266;
  localparam int watchdog_cycles = total_frame_words * 4 + 600;

  localparam mac_addr_t my_mac    = 48'h02_11_22_33_44_55;
  localparam ip_addr_t  my_ip     = 32'hc0a8_0a05;
  localparam udp_port_t my_port   = 16'd5001;
  localparam ip_addr_t  grp_ip    = 32'hef01_0203;
  localparam ip_addr_t  grp_mask  = 32'hffff_ff00;
  localparam ip_addr_t  peer_ip   = 32'hc0a8_0a63;
  localparam udp_port_t peer_port = 16'd40000;

  logic        mac_clk;
  logic        mac_rst;
  logic [63:0] mac_rx_data;
  logic [7:0]  mac_rx_data_valid;
  logic        mac_rx_good_frame;
  logic        mac_rx_bad_frame;
  logic        phy_rx_up;
  logic        local_enable;
  logic        app_rx_valid;
  logic        app_rx_end_of_frame;
  logic [63:0] app_rx_data;
  ip_addr_t    app_rx_source_ip;
  udp_port_t   app_rx_source_port;
  logic        app_rx_bad_frame;
  logic        app_rx_overrun;
  logic        app_rx_ack;
  logic        app_rx_overrun_ack;

  logic [7:0]  frame_bytes [256];
  int          frame_len;
  int          seed = 3408;
  // source port of the frame being built, one step per frame
  udp_port_t   src_port;

  // expected words of the current test
  logic [63:0] exp_data [max_words];
  // overrun, bad, eof
  logic [2:0]  exp_flags [max_words];
  // source port above source IP
  logic [47:0] exp_src [max_words];
  int          exp_count;
  logic        test_done;
  int          test_num;
  logic        all_done;
  int          got_count;
  int          error_count;

  // writer model while the application holds off
  logic        hold_ack;
  int          held_words;
  int          held_frames;
  logic        writer_blocked;

  udp_rx_top dut0 (
    .mac_clk               (mac_clk),
    .mac_rst               (mac_rst),
    .mac_rx_data           (mac_rx_data),
    .mac_rx_data_valid     (mac_rx_data_valid),
    .mac_rx_good_frame     (mac_rx_good_frame),
    .mac_rx_bad_frame      (mac_rx_bad_frame),
    .phy_rx_up             (phy_rx_up),
    .local_enable          (local_enable),
    .local_mac             (my_mac),
    .local_ip              (my_ip),
    .local_port            (my_port),
    .local_mc_recv_ip      (grp_ip),
    .local_mc_recv_ip_mask (grp_mask),
    .app_rx_valid          (app_rx_valid),
    .app_rx_end_of_frame   (app_rx_end_of_frame),
    .app_rx_data           (app_rx_data),
    .app_rx_source_ip      (app_rx_source_ip),
    .app_rx_source_port    (app_rx_source_port),
    .app_rx_bad_frame      (app_rx_bad_frame),
    .app_rx_overrun        (app_rx_overrun),
    .app_rx_ack            (app_rx_ack),
    .app_rx_overrun_ack    (app_rx_overrun_ack)
  );

  udp_rx_checker #(.max_words(max_words)) chk0 (
    .mac_clk             (mac_clk),
    .app_rx_valid        (app_rx_valid),
    .app_rx_ack          (app_rx_ack),
    .app_rx_end_of_frame (app_rx_end_of_frame),
    .app_rx_data         (app_rx_data),
    .app_rx_source_ip    (app_rx_source_ip),
    .app_rx_source_port  (app_rx_source_port),
    .app_rx_bad_frame    (app_rx_bad_frame),
    .app_rx_overrun      (app_rx_overrun),
    .exp_data            (exp_data),
    .exp_flags           (exp_flags),
    .exp_src             (exp_src),
    .exp_count           (exp_count),
    .test_done           (test_done),
    .test_num            (test_num),
    .all_done            (all_done),
    .got_count           (got_count),
    .error_count         (error_count)
  );

  initial begin
    mac_clk = 1'b0;
    forever #clk_half mac_clk = ~mac_clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge mac_clk);
    $display("watchdog: the run did not finish within %0d cycles", watchdog_cycles);
    $display("Something failed");
    $finish;
  end

  // payload word k is frame bytes 42+8k to 49+8k, first byte on top
  function automatic logic [63:0] expected_word(input int k);
    logic [63:0] w;
    int          idx;
    w = '0;
    for (int j = 0; j < 8; j++) begin
      idx = 42 + 8 * k + j;
      if (idx < frame_len) begin
        w[63 - 8 * j -: 8] = frame_bytes[idx];
      end
    end
    return w;
  endfunction

  task automatic build_frame(input mac_addr_t dmac, input logic [15:0] etype,
                             input logic [7:0] ver_ihl, input logic [7:0] proto,
                             input ip_addr_t dip, input udp_port_t dport, input int nwords);
    frame_len = nwords * 8;
    src_port  = src_port + 16'd1;
    for (int i = 0; i < frame_len; i++) begin
      frame_bytes[i] = 8'($random(seed));
    end
    for (int j = 0; j < 6; j++) begin
      frame_bytes[j]     = dmac[47 - 8 * j -: 8];
      frame_bytes[6 + j] = 8'h20 + 8'(j);
    end
    frame_bytes[12] = etype[15:8];
    frame_bytes[13] = etype[7:0];
    frame_bytes[14] = ver_ihl;
    frame_bytes[23] = proto;
    for (int j = 0; j < 4; j++) begin
      frame_bytes[26 + j] = peer_ip[31 - 8 * j -: 8];
      frame_bytes[30 + j] = dip[31 - 8 * j -: 8];
    end
    frame_bytes[34] = src_port[15:8];
    frame_bytes[35] = src_port[7:0];
    frame_bytes[36] = dport[15:8];
    frame_bytes[37] = dport[7:0];
  endtask

  // a write that finds a FIFO almost full is the last one before a cut
  task automatic queue_expected(input logic bad);
    int   npay;
    logic ovr;
    logic last;
    npay = frame_len / 8 - 6;
    for (int k = 0; k < npay && !writer_blocked; k++) begin
      ovr = hold_ack && (held_words >= pkt_afull_level || held_frames >= ctrl_afull_level);
      last = k == npay - 1;
      exp_data[exp_count]  = expected_word(k);
      exp_flags[exp_count] = {ovr, bad && last, last || ovr};
      exp_src[exp_count]   = {src_port, peer_ip};
      exp_count++;
      if (hold_ack) begin
        held_words++;
        if (k == 0) begin
          held_frames++;
        end
      end
      if (ovr) begin
        writer_blocked = 1'b1;
      end
    end
  endtask

  task automatic send_frame(input logic bad);
    int nwords;
    nwords = frame_len / 8;
    for (int w = 0; w < nwords; w++) begin
      @(negedge mac_clk);
      for (int j = 0; j < 8; j++) begin
        mac_rx_data[8 * j +: 8] = frame_bytes[8 * w + j];
      end
      mac_rx_data_valid = 8'hff;
      mac_rx_good_frame = (w == nwords - 1) && !bad;
      mac_rx_bad_frame  = (w == nwords - 1) && bad;
    end
    @(negedge mac_clk);
    mac_rx_data_valid = 8'h00;
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;
    repeat (4) @(negedge mac_clk);
  endtask

  task automatic run_frame(input mac_addr_t dmac, input logic [15:0] etype,
                           input logic [7:0] ver_ihl, input logic [7:0] proto,
                           input ip_addr_t dip, input udp_port_t dport, input int nwords,
                           input logic accepted, input logic bad);
    build_frame(dmac, etype, ver_ihl, proto, dip, dport, nwords);
    if (accepted) begin
      queue_expected(bad);
    end
    send_frame(bad);
  endtask

  task automatic wait_delivered();
    int cycles;
    cycles = 0;
    while (got_count != exp_count && cycles < 1000) begin
      @(negedge mac_clk);
      cycles++;
    end
  endtask

  task automatic finish_test(input int num);
    wait_delivered();
    // room for any stray word to show up
    repeat (8) @(negedge mac_clk);
    test_num  = num;
    test_done = 1'b1;
    @(negedge mac_clk);
    test_done = 1'b0;
    exp_count = 0;
  endtask

  initial begin
    mac_rst            = 1'b1;
    mac_rx_data        = '0;
    mac_rx_data_valid  = 8'h00;
    mac_rx_good_frame  = 1'b0;
    mac_rx_bad_frame   = 1'b0;
    phy_rx_up          = 1'b1;
    local_enable       = 1'b1;
    app_rx_ack         = 1'b1;
    app_rx_overrun_ack = 1'b0;
    src_port           = peer_port;
    exp_count          = 0;
    test_done          = 1'b0;
    test_num           = 0;
    all_done           = 1'b0;
    hold_ack           = 1'b0;
    held_words         = 0;
    held_frames        = 0;
    writer_blocked     = 1'b0;
    repeat (5) @(posedge mac_clk);
    @(negedge mac_clk);
    mac_rst = 1'b0;
    repeat (4) @(negedge mac_clk);

    // unicast
    run_frame(my_mac, ethertype_ipv4, 8'h45, 8'h11, my_ip, my_port, 10, 1'b1, 1'b0);
    run_frame(my_mac, ethertype_ipv4, 8'h45, 8'h11, my_ip, my_port, 9, 1'b1, 1'b0);
    finish_test(1);

    // one reject per header check
    run_frame(48'h02_11_22_33_44_56, ethertype_ipv4, 8'h45, 8'h11, my_ip, my_port, 9,
              1'b0, 1'b0);
    run_frame(my_mac, 16'h86dd, 8'h45, 8'h11, my_ip, my_port, 9, 1'b0, 1'b0);
    run_frame(my_mac, ethertype_ipv4, 8'h46, 8'h11, my_ip, my_port, 9, 1'b0, 1'b0);
    run_frame(my_mac, ethertype_ipv4, 8'h45, 8'h06, my_ip, my_port, 9, 1'b0, 1'b0);
    run_frame(my_mac, ethertype_ipv4, 8'h45, 8'h11, my_ip, my_port + 16'd1, 9, 1'b0, 1'b0);
    run_frame(my_mac, ethertype_ipv4, 8'h45, 8'h11, 32'h0a00_0099, my_port, 9, 1'b0, 1'b0);
    finish_test(2);

    // broadcast with masked group IP, then group MAC with exact group IP
    run_frame(mac_broadcast, ethertype_ipv4, 8'h45, 8'h11, 32'hef01_0277, my_port, 9,
              1'b1, 1'b0);
    run_frame(48'h01_00_5e_01_02_03, ethertype_ipv4, 8'h45, 8'h11, grp_ip, my_port, 9,
              1'b1, 1'b0);
    finish_test(3);

    run_frame(my_mac, ethertype_ipv4, 8'h45, 8'h11, my_ip, my_port, 11, 1'b1, 1'b1);
    finish_test(4);

    // enable gate
    @(negedge mac_clk);
    local_enable = 1'b0;
    repeat (3) @(negedge mac_clk);
    run_frame(my_mac, ethertype_ipv4, 8'h45, 8'h11, my_ip, my_port, 9, 1'b0, 1'b0);
    local_enable = 1'b1;
    repeat (3) @(negedge mac_clk);
    run_frame(my_mac, ethertype_ipv4, 8'h45, 8'h11, my_ip, my_port, 9, 1'b1, 1'b0);
    finish_test(5);

    // overrun, 8 words per frame until the payload FIFO is almost full
    @(negedge mac_clk);
    app_rx_ack = 1'b0;
    hold_ack   = 1'b1;
    repeat (9) begin
      run_frame(my_mac, ethertype_ipv4, 8'h45, 8'h11, my_ip, my_port, 14, 1'b1, 1'b0);
    end
    app_rx_ack = 1'b1;
    hold_ack   = 1'b0;
    wait_delivered();
    // writer stays stopped until the ack pulse
    run_frame(my_mac, ethertype_ipv4, 8'h45, 8'h11, my_ip, my_port, 10, 1'b1, 1'b0);
    app_rx_overrun_ack = 1'b1;
    repeat (3) @(negedge mac_clk);
    app_rx_overrun_ack = 1'b0;
    writer_blocked = 1'b0;
    repeat (3) @(negedge mac_clk);
    run_frame(my_mac, ethertype_ipv4, 8'h45, 8'h11, my_ip, my_port, 10, 1'b1, 1'b0);
    finish_test(6);

    all_done = 1'b1;
    @(negedge mac_clk);
    all_done = 1'b0;
    @(negedge mac_clk);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: tests/udp_rx_checker.sv
`timescale 1ns/1ns

module udp_rx_checker #(
  parameter int max_words = 512
) (
  input  logic                          mac_clk,
  input  logic                          app_rx_valid,
  input  logic                          app_rx_ack,
  input  logic                          app_rx_end_of_frame,
  input  logic [udp_rx_pkg::word_w-1:0] app_rx_data,
  input  udp_rx_pkg::ip_addr_t          app_rx_source_ip,
  input  udp_rx_pkg::udp_port_t         app_rx_source_port,
  input  logic                          app_rx_bad_frame,
  input  logic                          app_rx_overrun,
  input  logic [63:0]                   exp_data [max_words],
  input  logic [2:0]                    exp_flags [max_words],
  input  logic [47:0]                   exp_src [max_words],
  input  int                            exp_count,
  input  logic                          test_done,
  input  int                            test_num,
  input  logic                          all_done,
  output int                            got_count,
  output int                            error_count
);
  import udp_rx_pkg::*;

  int got = 0;
  int errs = 0;
  int errs_base = 0;
  int tests_run = 0;
  int tests_failed = 0;

  assign got_count   = got;
  assign error_count = errs;

  task automatic compare_field(input string name, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
    if (exp_v !== got_v) begin
      $display("CHECK FAILED t=%0t %s exp=%h got=%h", $time, name, exp_v, got_v);
      errs++;
    end
  endtask

  always @(posedge mac_clk) begin
    if (test_done) begin
      if (got != exp_count) begin
        $display("test %0d: expected %0d payload words but the DUT delivered %0d",
                 test_num, exp_count, got);
        errs++;
      end
      tests_run++;
      if (errs != errs_base) begin
        tests_failed++;
      end
      $display("test %0d finished: %s, %0d words, %0d errors", test_num,
               (errs == errs_base) ? "ok" : "FAILED", got, errs - errs_base);
      errs_base = errs;
      got = 0;
    end else if (app_rx_valid && app_rx_ack) begin
      if (got >= exp_count) begin
        $display("test %0d: the DUT delivered a word that no frame should produce",
                 test_num);
        errs++;
      end else begin
        compare_field("app_rx_data", exp_data[got], app_rx_data);
        compare_field("app_rx_end_of_frame", 64'(exp_flags[got][0]),
                      64'(app_rx_end_of_frame));
        compare_field("app_rx_bad_frame", 64'(exp_flags[got][1]), 64'(app_rx_bad_frame));
        compare_field("app_rx_overrun", 64'(exp_flags[got][2]), 64'(app_rx_overrun));
        compare_field("app_rx_source_ip", 64'(exp_src[got][31:0]), 64'(app_rx_source_ip));
        compare_field("app_rx_source_port", 64'(exp_src[got][47:32]),
                      64'(app_rx_source_port));
      end
      got++;
    end
    if (all_done) begin
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errs);
    end
  end

endmodule

// File: hw/udp_rx_top.sv
`timescale 1ns/1ns

module udp_rx_top (
  input  logic                          mac_clk,
  input  logic                          mac_rst,
  input  logic [udp_rx_pkg::word_w-1:0] mac_rx_data,
  input  logic [7:0]                    mac_rx_data_valid,
  input  logic                          mac_rx_good_frame,
  input  logic                          mac_rx_bad_frame,
  input  logic                          phy_rx_up,
  input  logic                          local_enable,
  input  udp_rx_pkg::mac_addr_t         local_mac,
  input  udp_rx_pkg::ip_addr_t          local_ip,
  input  udp_rx_pkg::udp_port_t         local_port,
  input  udp_rx_pkg::ip_addr_t          local_mc_recv_ip,
  input  udp_rx_pkg::ip_addr_t          local_mc_recv_ip_mask,
  output logic                          app_rx_valid,
  output logic                          app_rx_end_of_frame,
  output logic [udp_rx_pkg::word_w-1:0] app_rx_data,
  output udp_rx_pkg::ip_addr_t          app_rx_source_ip,
  output udp_rx_pkg::udp_port_t         app_rx_source_port,
  output logic                          app_rx_bad_frame,
  output logic                          app_rx_overrun,
  input  logic                          app_rx_ack,
  input  logic                          app_rx_overrun_ack
);

  mac_word_if      mac_if ();
  frame_verdict_if verdict_if ();
  payload_word_if  payload_if ();

  // same MAC words feed both the filter and the aligner
  assign mac_if.data       = mac_rx_data;
  assign mac_if.valid      = mac_rx_data_valid;
  assign mac_if.good_frame = mac_rx_good_frame;
  assign mac_if.bad_frame  = mac_rx_bad_frame;

  udp_header_filter filter0 (
    .mac_clk      (mac_clk),
    .mac_rst      (mac_rst),
    .mac          (mac_if.filter),
    .phy_rx_up    (phy_rx_up),
    .local_enable (local_enable),
    .local_mac    (local_mac),
    .local_ip     (local_ip),
    .local_port   (local_port),
    .mc_ip        (local_mc_recv_ip),
    .mc_ip_mask   (local_mc_recv_ip_mask),
    .verdict      (verdict_if.filter)
  );

  payload_aligner aligner0 (
    .mac_clk (mac_clk),
    .mac     (mac_if.aligner),
    .payload (payload_if.aligner)
  );

  app_rx_buffer buffer0 (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .verdict     (verdict_if.buffer),
    .payload     (payload_if.buffer),
    .rx_ack      (app_rx_ack),
    .overrun_ack (app_rx_overrun_ack),
    .rx_valid    (app_rx_valid),
    .rx_eof      (app_rx_end_of_frame),
    .rx_bad      (app_rx_bad_frame),
    .rx_overrun  (app_rx_overrun),
    .rx_data     (app_rx_data),
    .rx_src_ip   (app_rx_source_ip),
    .rx_src_port (app_rx_source_port)
  );

endmodule

// File: hw/payload_aligner.sv
`timescale 1ns/1ns

module payload_aligner (
  input  logic           mac_clk,
  mac_word_if.aligner    mac,
  payload_word_if.aligner payload
);

  logic [63:0] data_z;
  logic [63:0] data_r;
  logic        end_z;
  logic        end_r;
  logic        bad_z;

  always_ff @(posedge mac_clk) begin
    data_z <= mac.data;
    end_z  <= mac.good_frame | mac.bad_frame;
    bad_z  <= mac.bad_frame;
    data_r <= data_z;
    end_r  <= end_z;
  end

  // payload starts at byte 2 of a word, so six bytes come from the older
  // word and two from the newer one, byte-swapped to first byte on top
  assign payload.word = {data_r[23:16], data_r[31:24], data_r[39:32], data_r[47:40],
                         data_r[55:48], data_r[63:56], data_z[7:0], data_z[15:8]};

  // end strobe lines up with the word that holds the last MAC word
  assign payload.end_now  = end_z;
  assign payload.end_seen = end_r;
  assign payload.bad      = bad_z;

endmodule

// File: hw/udp_header_filter.sv
`timescale 1ns/1ns

module udp_header_filter (
  input  logic                  mac_clk,
  input  logic                  mac_rst,
  mac_word_if.filter            mac,
  input  logic                  phy_rx_up,
  input  logic                  local_enable,
  input  udp_rx_pkg::mac_addr_t local_mac,
  input  udp_rx_pkg::ip_addr_t  local_ip,
  input  udp_rx_pkg::udp_port_t local_port,
  input  udp_rx_pkg::ip_addr_t  mc_ip,
  input  udp_rx_pkg::ip_addr_t  mc_ip_mask,
  frame_verdict_if.filter       verdict
);
  import udp_rx_pkg::*;

  rx_state_t         state;
  logic              accept;
  logic              en_r;
  logic              en_rr;
  logic [word_w-1:0] data_z;
  logic [word_w-1:0] data_r;
  logic [7:0]        valid_z;
  logic              end_z;
  logic              end_r;
  ip_addr_t          src_ip;
  udp_port_t         src_port;
  mac_addr_t         dest_mac;
  ip_addr_t          dest_ip;
  udp_port_t         dest_port;
  logic              frame_start;
  logic              mac_ok;
  logic              ipv4_ok;
  logic              udp_ok;
  logic              ip_ok;
  logic              port_ok;

  // first byte on the wire sits in the lowest lane
  assign dest_mac  = {data_z[7:0], data_z[15:8], data_z[23:16],
                      data_z[31:24], data_z[39:32], data_z[47:40]};
  assign dest_port = {data_z[39:32], data_z[47:40]};
  // destination IP straddles header words 3 and 4
  assign dest_ip   = {data_r[55:48], data_r[63:56], data_z[7:0], data_z[15:8]};

  assign frame_start = (valid_z == 8'hff) && phy_rx_up;
  assign mac_ok  = (dest_mac == local_mac) || (dest_mac == mac_broadcast) ||
                   (dest_mac[47:24] == mc_mac_prefix);
  assign ipv4_ok = ({data_z[39:32], data_z[47:40]} == ethertype_ipv4) &&
                   (data_z[55:48] == ipv4_ver_ihl);
  assign udp_ok  = data_z[63:56] == ip_proto_udp;
  assign port_ok = dest_port == local_port;
  assign ip_ok   = (dest_ip == local_ip) || (dest_ip == mc_ip) ||
                   ((dest_ip & mc_ip_mask) == (mc_ip & mc_ip_mask));

  always_ff @(posedge mac_clk) begin
    data_z  <= mac.data;
    valid_z <= mac.valid;
    end_z   <= mac.good_frame | mac.bad_frame;
    data_r  <= data_z;
    end_r   <= end_z;
  end

  // source address fields
  always_ff @(posedge mac_clk) begin
    if (state == rx_hdr4) begin
      src_ip <= {data_z[23:16], data_z[31:24], data_z[39:32], data_z[47:40]};
    end
    if (state == rx_hdr5) begin
      src_port <= {data_z[23:16], data_z[31:24]};
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state  <= rx_idle;
      accept <= 1'b0;
      en_r   <= 1'b0;
      en_rr  <= 1'b0;
    end else begin
      en_r  <= local_enable;
      en_rr <= en_r;
      case (state)
        rx_idle: begin
          accept <= 1'b1;
          if (frame_start) begin
            if (mac_ok) begin
              state <= rx_hdr2;
            end else begin
              accept <= 1'b0;
              state  <= rx_data;
            end
          end
        end
        rx_hdr2: begin
          if (ipv4_ok) begin
            state <= rx_hdr3;
          end else begin
            accept <= 1'b0;
            state  <= rx_data;
          end
        end
        rx_hdr3: begin
          if (udp_ok) begin
            state <= rx_hdr4;
          end else begin
            accept <= 1'b0;
            state  <= rx_data;
          end
        end
        rx_hdr4: state <= rx_hdr5;
        rx_hdr5: begin
          if (port_ok && ip_ok) begin
            state <= rx_hdr6;
          end else begin
            accept <= 1'b0;
            state  <= rx_data;
          end
        end
        // checksums are not checked
        rx_hdr6: state <= rx_data;
        rx_data: begin
          if (end_r) begin
            state <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
      if (!en_rr) begin
        accept <= 1'b0;
      end
    end
  end

  assign verdict.accept   = accept;
  assign verdict.in_data  = state == rx_data;
  assign verdict.src_ip   = src_ip;
  assign verdict.src_port = src_port;

endmodule

// File: app_buffer/app_rx_buffer.sv
`timescale 1ns/1ns

module app_rx_buffer (
  input  logic                          mac_clk,
  input  logic                          mac_rst,
  frame_verdict_if.buffer               verdict,
  payload_word_if.buffer                payload,
  input  logic                          rx_ack,
  input  logic                          overrun_ack,
  output logic                          rx_valid,
  output logic                          rx_eof,
  output logic                          rx_bad,
  output logic                          rx_overrun,
  output logic [udp_rx_pkg::word_w-1:0] rx_data,
  output udp_rx_pkg::ip_addr_t          rx_src_ip,
  output udp_rx_pkg::udp_port_t         rx_src_port
);
  import udp_rx_pkg::*;

  app_state_t state;
  logic       first_word;
  logic       dvld;
  logic       fifo_afull;
  logic       pkt_afull;
  logic       ctrl_afull;
  logic       pkt_empty;
  logic       ctrl_empty;
  logic       pkt_wr_en;
  logic       ctrl_wr_en;
  logic       ctrl_rd_en;
  pkt_entry_t pkt_wr;
  pkt_entry_t pkt_rd;
  src_info_t  ctrl_wr;
  src_info_t  ctrl_rd;

  // payload word of an accepted frame, end cycle excluded
  assign dvld       = verdict.accept && verdict.in_data && !payload.end_seen;
  assign fifo_afull = pkt_afull || ctrl_afull;

  // an almost full FIFO cuts the frame short here
  assign pkt_wr = '{overrun: fifo_afull,
                    bad:     payload.bad,
                    eof:     payload.end_now || fifo_afull,
                    data:    payload.word};
  assign ctrl_wr = '{src_port: verdict.src_port, src_ip: verdict.src_ip};

  assign pkt_wr_en  = dvld && (state == app_run);
  assign ctrl_wr_en = pkt_wr_en && first_word;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state      <= app_run;
      first_word <= 1'b1;
    end else begin
      case (state)
        app_run: begin
          if (dvld) begin
            first_word <= pkt_wr.eof;
          end
          if (dvld && fifo_afull) begin
            state <= app_over;
          end
        end
        // hold off until the ack has gone high and low again
        app_over: begin
          if (overrun_ack) begin
            state <= app_wait;
          end
        end
        app_wait: begin
          if (!overrun_ack) begin
            state <= app_run;
          end
        end
        default: state <= app_run;
      endcase
    end
  end

  rx_word_fifo #(
    .width       ($bits(pkt_entry_t)),
    .depth       (pkt_fifo_depth),
    .afull_level (pkt_afull_level)
  ) pkt_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (pkt_wr_en),
    .wr_data     (pkt_wr),
    .rd_en       (rx_ack),
    .rd_data     (pkt_rd),
    .empty       (pkt_empty),
    .almost_full (pkt_afull)
  );

  rx_word_fifo #(
    .width       ($bits(src_info_t)),
    .depth       (ctrl_fifo_depth),
    .afull_level (ctrl_afull_level)
  ) ctrl_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (ctrl_wr_en),
    .wr_data     (ctrl_wr),
    .rd_en       (ctrl_rd_en),
    .rd_data     (ctrl_rd),
    .empty       (ctrl_empty),
    .almost_full (ctrl_afull)
  );

  // frame info leaves with the last word of its frame
  assign ctrl_rd_en = rx_ack && rx_valid && pkt_rd.eof && !ctrl_empty;

  assign rx_valid    = !pkt_empty;
  assign rx_eof      = pkt_rd.eof;
  assign rx_bad      = pkt_rd.bad;
  assign rx_overrun  = pkt_rd.overrun;
  assign rx_data     = pkt_rd.data;
  assign rx_src_ip   = ctrl_rd.src_ip;
  assign rx_src_port = ctrl_rd.src_port;

endmodule

// File: app_buffer/rx_word_fifo.sv
`timescale 1ns/1ns

module rx_word_fifo #(
  parameter int width       = 64,
  parameter int depth       = 64,
  parameter int afull_level = 56
) (
  input  logic             mac_clk,
  input  logic             mac_rst,
  input  logic             wr_en,
  input  logic [width-1:0] wr_data,
  input  logic             rd_en,
  output logic [width-1:0] rd_data,
  output logic             empty,
  output logic             almost_full
);

  // depth is a power of two, so pointers wrap on their own
  typedef logic [$clog2(depth)-1:0] ptr_t;
  typedef logic [$clog2(depth):0]   count_t;

  logic [width-1:0] mem [depth];
  ptr_t             wr_ptr;
  ptr_t             rd_ptr;
  count_t           count;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr_en && (count != count_t'(depth));
  assign do_rd = rd_en && !empty;

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry always shown
  assign rd_data     = mem[rd_ptr];
  assign empty       = count == '0;
  assign almost_full = count >= count_t'(afull_level);

endmodule

// File: common/payload_word_if.sv
`timescale 1ns/1ns

interface payload_word_if;
  import udp_rx_pkg::*;

  logic [word_w-1:0] word;
  // word is the last one of the frame
  logic              end_now;
  // frame ended on the previous cycle
  logic              end_seen;
  logic              bad;

  modport aligner (
    output word,
    output end_now,
    output end_seen,
    output bad
  );

  modport buffer (
    input word,
    input end_now,
    input end_seen,
    input bad
  );

endinterface

// File: common/frame_verdict_if.sv
`timescale 1ns/1ns

interface frame_verdict_if;
  import udp_rx_pkg::*;

  // frame passed every check so far
  logic      accept;
  // header walk is done, payload is flowing
  logic      in_data;
  ip_addr_t  src_ip;
  udp_port_t src_port;

  modport filter (
    output accept,
    output in_data,
    output src_ip,
    output src_port
  );

  modport buffer (
    input accept,
    input in_data,
    input src_ip,
    input src_port
  );

endinterface

// File: common/mac_word_if.sv
`timescale 1ns/1ns

interface mac_word_if;
  import udp_rx_pkg::*;

  logic [word_w-1:0] data;
  // one bit per byte lane
  logic [7:0]        valid;
  logic              good_frame;
  logic              bad_frame;

  modport filter (
    input data,
    input valid,
    input good_frame,
    input bad_frame
  );

  modport aligner (
    input data,
    input good_frame,
    input bad_frame
  );

endinterface

// File: common/udp_rx_pkg.sv
package udp_rx_pkg;

  localparam int word_w = 64;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;

  // destination MAC classes
  localparam mac_addr_t   mac_broadcast = 48'hffff_ffff_ffff;
  localparam logic [23:0] mc_mac_prefix = 24'h01_00_5e;

  // IPv4 and UDP header values
  localparam logic [15:0] ethertype_ipv4 = 16'h0800;
  localparam logic [7:0]  ipv4_ver_ihl   = 8'h45;
  localparam logic [7:0]  ip_proto_udp   = 8'h11;

  // words before the first payload word
  localparam int hdr_words = 6;

  localparam int pkt_fifo_depth   = 64;
  localparam int ctrl_fifo_depth  = 16;
  localparam int pkt_afull_level  = 56;
  localparam int ctrl_afull_level = 12;

  // idle, one state per remaining header word, then data
  typedef enum logic [$clog2(hdr_words + 1)-1:0] {
    rx_idle,
    rx_hdr2,
    rx_hdr3,
    rx_hdr4,
    rx_hdr5,
    rx_hdr6,
    rx_data
  } rx_state_t;

  typedef enum logic [1:0] {
    app_run,
    app_over,
    app_wait
  } app_state_t;

  // control FIFO entry, one per frame
  typedef struct packed {
    udp_port_t src_port;
    ip_addr_t  src_ip;
  } src_info_t;

  // payload FIFO entry
  typedef struct packed {
    logic              overrun;
    logic              bad;
    logic              eof;
    logic [word_w-1:0] data;
  } pkt_entry_t;

endpackage
